// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fpt_table_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+source
source/fpt_pkg.sv
source/fpt_lookup_if.sv
source/fpt_index_decode.sv
source/fpt_table_ram.sv
source/fpt_result_stage.sv
source/fpt_table_top.sv
tb/fpt_table_sva.sv
tb/fpt_table_tb.sv

// ==== source/fpt_consts.svh ====
`ifndef FPT_CONSTS_SVH
`define FPT_CONSTS_SVH

// ####################
// Operand format
// ####################

// Tag 67:66, exponent 65:54, mantissa 53:0
`define FPT_WORD_W      68
`define FPT_EXP_W       12
`define FPT_EXP_LSB     54
`define FPT_MANT_MSB    53
`define FPT_SIGN_BIT    64

// ####################
// Seed table
// ####################

`define FPT_TABLE_DEPTH 512
`define FPT_ADDR_W      9
`define FPT_CODE_W      6

// Exponent window bases, one per operation group
`define FPT_RECIP_BASE  2040
`define FPT_RSQRT_BASE  2041
`define FPT_EXP_BASE    2045

// Highest exponent offset inside a window
`define FPT_WIN_MAX     6

// ####################
// Truncation field
// ####################

`define FPT_FIELD_LSB   47
`define FPT_MASK_W      7

`endif

// ==== source/fpt_index_decode.sv ====
`include "fpt_consts.svh"

module fpt_index_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd,
  input  fpt_pkg::fpt_op_t   op,
  input  fpt_pkg::fpt_word_t a,
  fpt_lookup_if.dec          req
);
  import fpt_pkg::*;

  logic [2:0]              op_bits;
  fpt_exp_t                exp_in;
  fpt_exp_t                base;
  fpt_exp_t                d;
  logic                    in_window;
  logic                    d_active;
  logic                    is_table;
  logic [2:0]              lead_shift;
  logic [`FPT_CODE_W-2:0]  lead_bits;
  logic                    code_top;
  fpt_code_t               code;
  logic [1:0]              sub_slot;
  logic                    bank;
  fpt_addr_t               index;
  fpt_mask_t               ones;
  fpt_mask_t               mask;
  logic                    sign_fix;

  assign op_bits = op;
  assign exp_in  = a[`FPT_EXP_LSB +: `FPT_EXP_W];

  // ####################
  // Exponent window
  // ####################

  always_comb begin
    case (op)
      OP_RECIP,
      OP_TRUNC1,
      OP_TRUNC2: base = fpt_exp_t'(`FPT_RECIP_BASE);
      OP_RSQRT:  base = fpt_exp_t'(`FPT_RSQRT_BASE);
      default:   base = fpt_exp_t'(`FPT_EXP_BASE);
    endcase
  end

  // Below the base wraps to a large value and falls out of the window
  assign d         = exp_in - base;
  assign in_window = (d <= fpt_exp_t'(`FPT_WIN_MAX));
  assign d_active  = in_window && (d != '0);

  // ####################
  // Segment code and index
  // ####################

  assign is_table = fpt_is_table(op);

  // Top d-1 mantissa bits, right aligned
  assign lead_shift = 3'(`FPT_WIN_MAX) - d[2:0];
  assign lead_bits  = a[`FPT_MANT_MSB -: (`FPT_CODE_W - 1)] >> lead_shift;

  // Exponent parity takes the top code bit for rsqrt
  assign code_top = (op == OP_RSQRT) ? a[`FPT_EXP_LSB] : 1'b1;

  always_comb begin
    if (is_table && d_active) begin
      code = {code_top, lead_bits};
    end else begin
      code = '0;
    end
  end

  assign bank     = (op == OP_EXP2_HI);
  assign sub_slot = (is_table && !bank) ? op_bits[1:0] : 2'b00;

  // bank * 256 + code * 4 + sub_slot
  assign index = {bank, code, sub_slot};

  // ####################
  // Field mask
  // ####################

  assign ones = d_active ? fpt_mask_t'((8'd1 << d[2:0]) - 8'd1) : '0;

  always_comb begin
    case (op)
      OP_TRUNC1,
      OP_TRUNC_HI: mask = ones << 1;
      OP_TRUNC2:   mask = ones << 2;
      default:     mask = '0;
    endcase
  end

  assign sign_fix = (op == OP_RECIP) || (op == OP_EXP2);

  // ####################
  // Request register
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      req.is_table <= is_table;
      req.addr     <= index;
      req.mask     <= mask;
      req.sign_fix <= sign_fix;
      req.operand  <= a;
    end
  end

endmodule

// ==== source/fpt_lookup_if.sv ====
`include "fpt_consts.svh"

interface fpt_lookup_if;
  import fpt_pkg::*;

  // One decoded request, one cycle after the read strobe
  logic      valid;
  logic      is_table;
  fpt_addr_t addr;
  fpt_mask_t mask;
  logic      sign_fix;
  fpt_word_t operand;

  // Producer side
  modport dec (
    output valid,
    output is_table,
    output addr,
    output mask,
    output sign_fix,
    output operand
  );

  // Consumer side
  modport res (
    input valid,
    input is_table,
    input addr,
    input mask,
    input sign_fix,
    input operand
  );

endinterface

// ==== source/fpt_pkg.sv ====
`include "fpt_consts.svh"

package fpt_pkg;

  // ####################
  // Vector types
  // ####################

  typedef logic [`FPT_WORD_W-1:0] fpt_word_t;
  typedef logic [`FPT_EXP_W-1:0]  fpt_exp_t;
  typedef logic [`FPT_ADDR_W-1:0] fpt_addr_t;
  typedef logic [`FPT_CODE_W-1:0] fpt_code_t;
  typedef logic [`FPT_MASK_W-1:0] fpt_mask_t;

  // ####################
  // Operations
  // ####################

  // Five table reads, then three field masks
  typedef enum logic [2:0] {
    OP_RECIP    = 3'd0,
    OP_RSQRT    = 3'd1,
    OP_EXP2     = 3'd2,
    OP_LOG2     = 3'd3,
    OP_EXP2_HI  = 3'd4,
    OP_TRUNC1   = 3'd5,
    OP_TRUNC2   = 3'd6,
    OP_TRUNC_HI = 3'd7
  } fpt_op_t;

  // True for the ops that return a table seed
  function automatic logic fpt_is_table(fpt_op_t op);
    logic result;
    result = (op inside {OP_RECIP, OP_RSQRT, OP_EXP2, OP_LOG2, OP_EXP2_HI});
    return result;
  endfunction

endpackage

// ==== source/fpt_result_stage.sv ====
`include "fpt_consts.svh"

module fpt_result_stage (
  input  logic               clk,
  input  logic               reset,
  fpt_lookup_if.res          req,
  input  fpt_pkg::fpt_word_t seed,
  output fpt_pkg::fpt_word_t res,
  output logic               res_valid
);
  import fpt_pkg::*;

  logic      pend_valid;
  logic      pend_table;
  logic      pend_flip;
  fpt_mask_t pend_field;
  fpt_word_t flip_word;
  fpt_word_t seed_fixed;
  fpt_word_t trunc_word;
  fpt_word_t res_next;

  // ####################
  // Align with RAM data
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= req.valid;
    end
  end

  // Only the sign bit and the kept field survive past here
  always_ff @(posedge clk) begin
    pend_table <= req.is_table;
    pend_flip  <= req.sign_fix & req.operand[`FPT_SIGN_BIT];
    pend_field <= req.operand[`FPT_FIELD_LSB +: `FPT_MASK_W] & req.mask;
  end

  // ####################
  // Result select
  // ####################

  always_comb begin
    flip_word = '0;
    flip_word[`FPT_SIGN_BIT] = pend_flip;
    seed_fixed = seed ^ flip_word;

    trunc_word = '0;
    trunc_word[`FPT_FIELD_LSB +: `FPT_MASK_W] = pend_field;

    res_next = pend_table ? seed_fixed : trunc_word;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= pend_valid;
      if (pend_valid) begin
        res <= res_next;
      end
    end
  end

endmodule

// ==== source/fpt_table_ram.sv ====
`include "fpt_consts.svh"

module fpt_table_ram (
  input  logic               clk,
  input  logic               wr,
  input  fpt_pkg::fpt_addr_t wr_addr,
  input  fpt_pkg::fpt_word_t wr_data,
  input  fpt_pkg::fpt_addr_t rd_addr,
  output fpt_pkg::fpt_word_t rd_data
);
  import fpt_pkg::*;

  // Seed storage, loaded entry by entry
  fpt_word_t mem [`FPT_TABLE_DEPTH];

  // ####################
  // Write port
  // ####################

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ####################
  // Read port
  // ####################

  // Old contents on a same-edge write to the read address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== source/fpt_table_top.sv ====
`include "fpt_consts.svh"

module fpt_table_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd,
  input  fpt_pkg::fpt_op_t   op,
  input  fpt_pkg::fpt_word_t a,
  input  logic               wr,
  input  fpt_pkg::fpt_word_t b,
  output fpt_pkg::fpt_word_t res,
  output logic               res_valid
);
  import fpt_pkg::*;

  fpt_addr_t wr_addr;
  fpt_word_t seed;

  fpt_lookup_if lookup ();

  // Write address from b[53:45]
  assign wr_addr = b[`FPT_MANT_MSB -: `FPT_ADDR_W];

  fpt_index_decode u_dec (
    .clk   (clk),
    .reset (reset),
    .rd    (rd),
    .op    (op),
    .a     (a),
    .req   (lookup.dec)
  );

  fpt_table_ram u_ram (
    .clk     (clk),
    .wr      (wr),
    .wr_addr (wr_addr),
    .wr_data (a),
    .rd_addr (lookup.addr),
    .rd_data (seed)
  );

  fpt_result_stage u_res (
    .clk       (clk),
    .reset     (reset),
    .req       (lookup.res),
    .seed      (seed),
    .res       (res),
    .res_valid (res_valid)
  );

endmodule

// ==== tb/fpt_table_sva.sv ====
`include "fpt_consts.svh"

module fpt_table_sva (
  input logic               clk,
  input logic               reset,
  input logic               rd,
  input fpt_pkg::fpt_op_t   op,
  input fpt_pkg::fpt_word_t a,
  input logic               res_valid,
  input fpt_pkg::fpt_addr_t req_addr,
  input fpt_pkg::fpt_mask_t req_mask
);
  import fpt_pkg::*;

  // Failed assertions so far
  int   error_count = 0;
  int   exp_val;
  int   win_lo;
  logic in_win;

  // First exponent inside the window of the current op
  always_comb begin
    exp_val = int'(a[`FPT_EXP_LSB +: `FPT_EXP_W]);
    if (op == OP_RSQRT) begin
      win_lo = `FPT_RSQRT_BASE + 1;
    end else if (op inside {OP_RECIP, OP_TRUNC1, OP_TRUNC2}) begin
      win_lo = `FPT_RECIP_BASE + 1;
    end else begin
      win_lo = `FPT_EXP_BASE + 1;
    end
    in_win = (exp_val >= win_lo) && (exp_val < win_lo + `FPT_WIN_MAX);
  end

  // ####################
  // Pipeline timing
  // ####################

  // Strobe sampled at one edge, result registered two edges later
  rd_to_valid: assert property (@(posedge clk) disable iff (reset)
    rd |-> ##3 res_valid)
    else begin
      error_count++;
      $error("Read strobe not followed by a result two cycles later");
    end

  valid_from_rd: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> $past(rd, 3))
    else begin
      error_count++;
      $error("Result strobe without a matching read");
    end

  // ####################
  // Reset
  // ####################

  valid_low_in_reset: assert property (@(posedge clk)
    reset |=> !res_valid)
    else begin
      error_count++;
      $error("Result strobe high during reset");
    end

  // No read can reach the output in the first three cycles
  valid_low_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !res_valid [*3])
    else begin
      error_count++;
      $error("Result strobe high right after reset");
    end

  // ####################
  // Decode ranges
  // ####################

  // Upper half of the table belongs to the high exp2 bank
  index_bank: assert property (@(posedge clk) disable iff (reset)
    rd |=> ((int'(req_addr) >= `FPT_TABLE_DEPTH / 2) == ($past(op) == OP_EXP2_HI)))
    else begin
      error_count++;
      $error("Table index outside the bank of its operation");
    end

  mask_outside_window: assert property (@(posedge clk) disable iff (reset)
    rd && !in_win |=> (req_mask == '0))
    else begin
      error_count++;
      $error("Field mask not empty outside the exponent window");
    end

endmodule

bind fpt_table_top fpt_table_sva u_sva (
  .clk       (clk),
  .reset     (reset),
  .rd        (rd),
  .op        (op),
  .a         (a),
  .res_valid (res_valid),
  .req_addr  (lookup.addr),
  .req_mask  (lookup.mask)
);

// ==== tb/fpt_table_tb.sv ====
`include "fpt_consts.svh"

module fpt_table_tb;
  import fpt_pkg::*;

  localparam int RESET_CYCLES   = 5;
  localparam int READ_BUDGET    = 150;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + `FPT_TABLE_DEPTH + READ_BUDGET + 100;

  logic      clk;
  logic      reset;
  logic      rd;
  fpt_op_t   op;
  fpt_word_t a;
  logic      wr;
  fpt_word_t b;
  fpt_word_t res;
  logic      res_valid;

  // Expected results travel alongside the DUT pipeline
  fpt_word_t exp_in;
  fpt_word_t exp_q1;
  fpt_word_t exp_q2;
  fpt_word_t exp_q3;
  logic      v_in;
  logic      v_q1;
  logic      v_q2;
  logic      v_q3;

  fpt_word_t   table_m [`FPT_TABLE_DEPTH];
  logic [31:0] lcg_state;
  string       test_name;
  int          issued_count;
  int          seen_count;
  int          cycle_count;

  fpt_table_top u_fpt_table_top (
    .clk       (clk),
    .reset     (reset),
    .rd        (rd),
    .op        (op),
    .a         (a),
    .wr        (wr),
    .b         (b),
    .res       (res),
    .res_valid (res_valid)
  );

  always #50 clk = ~clk;

  // ####################
  // Reference model
  // ####################

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function fpt_word_t random_word();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    w0 = lcg_next();
    w1 = lcg_next();
    w2 = lcg_next();
    return {w2[3:0], w1, w0};
  endfunction

  function fpt_word_t make_operand(int exp_val);
    fpt_word_t w;
    w = random_word();
    w[65:54] = exp_val[11:0];
    return w;
  endfunction

  function int window_base(fpt_op_t o);
    if (o inside {OP_RECIP, OP_TRUNC1, OP_TRUNC2}) return `FPT_RECIP_BASE;
    if (o == OP_RSQRT) return `FPT_RSQRT_BASE;
    return `FPT_EXP_BASE;
  endfunction

  function fpt_addr_t rule_index(fpt_op_t o, fpt_word_t w);
    int         d;
    logic [5:0] code;
    int         slot;
    d = int'(w[65:54]) - window_base(o);
    code = '0;
    if (d >= 1 && d <= 6) begin
      code[5] = (o == OP_RSQRT) ? w[54] : 1'b1;
      for (int i = 0; i < d - 1; i++) begin
        code[d-2-i] = w[53-i];
      end
    end
    slot = (o == OP_EXP2_HI) ? 256 : int'(o);
    return fpt_addr_t'(int'(code) * 4 + slot);
  endfunction

  function fpt_word_t expected(fpt_op_t o, fpt_word_t w);
    int         d;
    logic [8:0] m;
    fpt_word_t  r;
    r = '0;
    if (o inside {OP_RECIP, OP_RSQRT, OP_EXP2, OP_LOG2, OP_EXP2_HI}) begin
      r = table_m[rule_index(o, w)];
      if ((o == OP_RECIP || o == OP_EXP2) && w[64]) r[64] = ~r[64];
    end else begin
      d = int'(w[65:54]) - window_base(o);
      m = '0;
      if (d >= 1 && d <= 6) m = (9'd1 << d) - 9'd1;
      m = (o == OP_TRUNC2) ? (m << 2) : (m << 1);
      for (int k = 0; k < 7; k++) begin
        if (m[k]) r[47+k] = w[47+k];
      end
    end
    return r;
  endfunction

  // ####################
  // Stimulus tasks
  // ####################

  task issue_read(fpt_op_t o, fpt_word_t w);
    @(posedge clk);
    rd     <= 1'b1;
    wr     <= 1'b0;
    op     <= o;
    a      <= w;
    exp_in <= expected(o, w);
    v_in   <= 1'b1;
    issued_count++;
  endtask

  task write_entry(fpt_addr_t addr, fpt_word_t data);
    fpt_word_t addr_word;
    addr_word = '0;
    addr_word[53:45] = addr;
    @(posedge clk);
    wr   <= 1'b1;
    rd   <= 1'b0;
    a    <= data;
    b    <= addr_word;
    v_in <= 1'b0;
    table_m[addr] = data;
  endtask

  task idle();
    @(posedge clk);
    rd   <= 1'b0;
    wr   <= 1'b0;
    v_in <= 1'b0;
  endtask

  // One below the window, the window, one above
  task sweep_window(fpt_op_t o);
    int base;
    base = window_base(o);
    for (int e = base - 1; e <= base + 7; e++) begin
      issue_read(o, make_operand(e));
    end
    idle();
  endtask

  // ####################
  // Checks
  // ####################

  always @(posedge clk) begin
    exp_q1 <= exp_in;
    exp_q2 <= exp_q1;
    exp_q3 <= exp_q2;
    if (reset) begin
      v_q1 <= 1'b0;
      v_q2 <= 1'b0;
      v_q3 <= 1'b0;
    end else begin
      v_q1 <= v_in;
      v_q2 <= v_q1;
      v_q3 <= v_q2;
    end
    if (res_valid) seen_count <= seen_count + 1;
  end

  result_check: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> (res == exp_q3))
    else begin
      $display("Mismatch in %s: expected %h, actual %h", test_name,
               $sampled(exp_q3), $sampled(res));
      $display("SOME TESTS FAILED");
      $fatal(1);
    end

  order_check: assert property (@(posedge clk) disable iff (reset)
    res_valid == v_q3)
    else begin
      $display("Result strobe out of step with the issued reads in %s", test_name);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (u_fpt_table_top.u_sva.error_count != 0) begin
      $display("Bound assertion on the DUT failed in %s", test_name);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in %s", cycle_count, test_name);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  // ####################
  // Test sequence
  // ####################

  initial begin
    fpt_word_t w;
    clk = 1'b0;
    reset = 1'b1;
    rd = 1'b0;
    op = OP_RECIP;
    a = '0;
    wr = 1'b0;
    b = '0;
    exp_in = '0;
    v_in = 1'b0;
    lcg_state = 32'h5ea0_55c9;
    issued_count = 0;
    seen_count = 0;
    cycle_count = 0;
    test_name = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    test_name = "table_load";
    for (int i = 0; i < `FPT_TABLE_DEPTH; i++) begin
      write_entry(fpt_addr_t'(i), random_word());
    end
    idle();

    test_name = "window_sweep";
    sweep_window(OP_RECIP);
    sweep_window(OP_RSQRT);
    sweep_window(OP_EXP2);
    sweep_window(OP_LOG2);

    // Exponent bit 64 set inside the windows, clear at 12'h3ff
    test_name = "sign_fix";
    issue_read(OP_RECIP, make_operand(`FPT_RECIP_BASE + 3));
    issue_read(OP_RECIP, make_operand(12'h3ff));
    issue_read(OP_EXP2, make_operand(`FPT_EXP_BASE + 2));
    issue_read(OP_EXP2, make_operand(12'h3ff));
    issue_read(OP_LOG2, make_operand(`FPT_EXP_BASE + 2));
    issue_read(OP_LOG2, make_operand(12'h3ff));
    idle();

    test_name = "upper_bank";
    sweep_window(OP_EXP2_HI);
    issue_read(OP_RECIP, make_operand(0));
    issue_read(OP_EXP2, make_operand(0));
    issue_read(OP_LOG2, make_operand(4095));
    idle();

    test_name = "truncate";
    sweep_window(OP_TRUNC1);
    sweep_window(OP_TRUNC2);
    sweep_window(OP_TRUNC_HI);

    test_name = "back_to_back";
    w = make_operand(`FPT_RECIP_BASE + 4);
    issue_read(OP_RECIP, w);
    issue_read(OP_LOG2, make_operand(`FPT_EXP_BASE + 5));
    write_entry(rule_index(OP_RECIP, w) ^ 9'h100, random_word());
    issue_read(OP_RECIP, w);
    write_entry(rule_index(OP_RECIP, w), random_word());
    issue_read(OP_RECIP, w);
    issue_read(OP_RSQRT, make_operand(`FPT_RSQRT_BASE + 6));
    issue_read(OP_RECIP, w);
    idle();

    while (seen_count != issued_count) @(posedge clk);
    repeat (2) @(posedge clk);
    if (seen_count == issued_count && u_fpt_table_top.u_sva.error_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("%0d results for %0d reads, %0d bound assertion failures",
               seen_count, issued_count, u_fpt_table_top.u_sva.error_count);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

endmodule
